/* microcode_regs.f */
rtl/ao_regs_pkg.sv
rtl/instr_latch.sv
rtl/size_decoder.sv
rtl/pc_unit.sv
rtl/operand_unit.sv
rtl/address_unit.sv
rtl/microcode_regs.sv
tests/microcode_regs_tb.sv

/* rtl/address_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus address register and exception vector number.
// The address steps by size or loads immediates and vectors.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module address_unit import ao_regs_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    input  addr_ctl_e addr_ctl,
    input  trap_ctl_e trap_ctl,
    input  size_t     size,
    input  half_t     ir,
    input  prefetch_t prefetch_ir,
    input  trap_t     decoder_trap,
    output word_t     address,
    output logic      address_type,
    output trap_t     trap
);

    word_t step;

    // Byte access through A7 keeps the stack word aligned
    assign step = (size[0] && ir[2:0] == 3'b111) ? 32'd2 : {{(WORD_W-SIZE_W){1'b0}}, size};

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            address <= '0;
        end else begin
            case (addr_ctl)
                ADDR_INCR_BY_SIZE: address <= address + step;
                ADDR_DECR_BY_SIZE: address <= address - step;
                ADDR_INCR_BY_2:    address <= address + 32'd2;
                ADDR_FROM_IMM_16:  address <= {{16{prefetch_ir[79]}}, prefetch_ir[79:64]};
                ADDR_FROM_IMM_32:  address <= prefetch_ir[79:48];
                ADDR_FROM_TRAP:    address <= {{(WORD_W-TRAP_W-2){1'b0}}, trap, 2'b00};
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n)
            address_type <= 1'b0;
        else if (addr_ctl != ADDR_IDLE)
            address_type <= 1'b0;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            trap <= '0;
        end else begin
            case (trap_ctl)
                TRAP_ILLEGAL_INSTR: trap <= TRAP_VEC_ILLEGAL;
                TRAP_DIV_BY_ZERO:   trap <= TRAP_VEC_DIV_ZERO;
                TRAP_CHK:           trap <= TRAP_VEC_CHK;
                TRAP_TRAPV:         trap <= TRAP_VEC_TRAPV;
                TRAP_PRIVIL_VIOLAT: trap <= TRAP_VEC_PRIVILEGE;
                TRAP_TRACE:         trap <= TRAP_VEC_TRACE;
                TRAP_TRAP:          trap <= TRAP_VEC_TRAP_BASE + {4'b0000, ir[3:0]};
                TRAP_FROM_DECODER:  trap <= decoder_trap;
                default: ;
            endcase
        end
    end

endmodule

/* rtl/ao_regs_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the microcode register file.
// Widths, control field encodings, exception vectors
// and one-hot size codes used by every register group.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ao_regs_pkg;

    localparam int WORD_W     = 32;
    localparam int HALF_W     = 16;
    localparam int PREFETCH_W = 80;
    localparam int SIZE_W     = 3;
    localparam int TRAP_W     = 8;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [HALF_W-1:0]     half_t;
    typedef logic [PREFETCH_W-1:0] prefetch_t;
    typedef logic [SIZE_W-1:0]     size_t;
    typedef logic [TRAP_W-1:0]     trap_t;

    // One-hot operand size whose value is the byte count
    localparam size_t SZ_NONE = 3'b000;
    localparam size_t SZ_BYTE = 3'b001;
    localparam size_t SZ_WORD = 3'b010;
    localparam size_t SZ_LONG = 3'b100;

    typedef enum logic [2:0] {
        PC_IDLE, PC_FROM_RESULT, PC_INCR_BY_2, PC_INCR_BY_4, PC_INCR_BY_SIZE,
        PC_FROM_PREFETCH_IR, PC_INCR_BY_2_IN_MAIN_LOOP
    } pc_ctl_e;

    typedef enum logic [3:0] {
        SIZE_IDLE, SIZE_BYTE, SIZE_WORD, SIZE_LONG, SIZE_1, SIZE_1_PLUS,
        SIZE_2, SIZE_3, SIZE_4, SIZE_5, SIZE_6
    } size_ctl_e;

    typedef enum logic [3:0] {
        OP1_IDLE, OP1_FROM_OP2, OP1_FROM_DATA, OP1_FROM_IMMEDIATE, OP1_FROM_RESULT,
        OP1_MOVEQ, OP1_FROM_PC, OP1_LOAD_ZEROS, OP1_LOAD_ONES
    } op1_ctl_e;

    typedef enum logic [2:0] {
        OP2_IDLE, OP2_FROM_OP1, OP2_LOAD_1, OP2_ADDQ_SUBQ, OP2_MOVE_OFFSET, OP2_DECR_BY_1
    } op2_ctl_e;

    typedef enum logic [2:0] {
        ADDR_IDLE, ADDR_INCR_BY_SIZE, ADDR_DECR_BY_SIZE, ADDR_INCR_BY_2,
        ADDR_FROM_IMM_16, ADDR_FROM_IMM_32, ADDR_FROM_TRAP
    } addr_ctl_e;

    typedef enum logic [3:0] {
        TRAP_IDLE, TRAP_ILLEGAL_INSTR, TRAP_DIV_BY_ZERO, TRAP_CHK, TRAP_TRAPV,
        TRAP_PRIVIL_VIOLAT, TRAP_TRACE, TRAP_TRAP, TRAP_FROM_DECODER
    } trap_ctl_e;

    typedef enum logic [1:0] {IR_IDLE, IR_LOAD_WHEN_PREFETCH_VALID} ir_ctl_e;

    typedef enum logic [1:0] {STOP_IDLE, STOP_SET, STOP_CLEAR} stop_ctl_e;

    // Exception vector numbers
    localparam trap_t TRAP_VEC_ILLEGAL   = 8'd4;
    localparam trap_t TRAP_VEC_DIV_ZERO  = 8'd5;
    localparam trap_t TRAP_VEC_CHK       = 8'd6;
    localparam trap_t TRAP_VEC_TRAPV     = 8'd7;
    localparam trap_t TRAP_VEC_PRIVILEGE = 8'd8;
    localparam trap_t TRAP_VEC_TRACE     = 8'd9;
    localparam trap_t TRAP_VEC_TRAP_BASE = 8'd32;

    // Nonzero so a divide sees a valid operand out of reset
    localparam word_t OPERAND_RESET_VALUE = 32'hFFFF_FFFF;

endpackage

/* rtl/instr_latch.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction word register and stop flag.
// Also decides when the main loop may move to the next word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module instr_latch import ao_regs_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    input  ir_ctl_e   ir_ctl,
    input  stop_ctl_e stop_ctl,
    input  prefetch_t prefetch_ir,
    input  logic      prefetch_ir_valid,
    input  trap_t     decoder_trap,
    output half_t     ir,
    output logic      stop_flag,
    output logic      main_loop_advance
);

    assign main_loop_advance = prefetch_ir_valid && (decoder_trap == '0) && !stop_flag;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ir <= '0;
        end else if (ir_ctl == IR_LOAD_WHEN_PREFETCH_VALID && prefetch_ir_valid && !stop_flag) begin
            ir <= prefetch_ir[79:64];
        end
    end

    // STOP instruction holds the core until cleared
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            stop_flag <= 1'b0;
        end else if (stop_ctl == STOP_SET) begin
            stop_flag <= 1'b1;
        end else if (stop_ctl == STOP_CLEAR) begin
            stop_flag <= 1'b0;
        end
    end

    // Sequencer must present a defined stop request every cycle
    stop_ctl_known: assert property (@(posedge clock) disable iff (!reset_n)
        !$isunknown(stop_ctl) && (stop_ctl inside {STOP_IDLE, STOP_SET, STOP_CLEAR}));

endmodule

/* rtl/microcode_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Microcode controlled register file of the core.
// Connects the register groups, adds no latency.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module microcode_regs import ao_regs_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  ir_ctl_e    ir_ctl,
    input  stop_ctl_e  stop_ctl,
    input  pc_ctl_e    pc_ctl,
    input  size_ctl_e  size_ctl,
    input  op1_ctl_e   op1_ctl,
    input  op2_ctl_e   op2_ctl,
    input  addr_ctl_e  addr_ctl,
    input  trap_ctl_e  trap_ctl,
    input  prefetch_t  prefetch_ir,
    input  logic       prefetch_ir_valid,
    input  word_t      data_read,
    input  word_t      result,
    input  trap_t      decoder_trap,
    output half_t      ir,
    output logic       stop_flag,
    output word_t      pc,
    output logic [1:0] pc_change,
    output size_t      size,
    output word_t      operand1,
    output word_t      operand2,
    output word_t      address,
    output logic       address_type,
    output trap_t      trap
);

    logic  main_loop_advance;
    word_t pc_valid;

    instr_latch u_instr_latch (.clock, .reset_n, .ir_ctl, .stop_ctl, .prefetch_ir,
        .prefetch_ir_valid, .decoder_trap, .ir, .stop_flag, .main_loop_advance);

    size_decoder u_size_decoder (.clock, .reset_n, .size_ctl, .ir, .size);

    pc_unit u_pc_unit (.clock, .reset_n, .pc_ctl, .main_loop_advance, .size, .result,
        .prefetch_ir, .pc, .pc_valid, .pc_change);

    operand_unit u_operand_unit (.clock, .reset_n, .op1_ctl, .op2_ctl, .size, .ir,
        .data_read, .prefetch_ir, .result, .pc_valid, .operand1, .operand2);

    address_unit u_address_unit (.clock, .reset_n, .addr_ctl, .trap_ctl, .size, .ir,
        .prefetch_ir, .decoder_trap, .address, .address_type, .trap);

endmodule

/* rtl/operand_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU operand registers.
// Loaded values are sign extended by the current size.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module operand_unit import ao_regs_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    input  op1_ctl_e  op1_ctl,
    input  op2_ctl_e  op2_ctl,
    input  size_t     size,
    input  half_t     ir,
    input  word_t     data_read,
    input  prefetch_t prefetch_ir,
    input  word_t     result,
    input  word_t     pc_valid,
    output word_t     operand1,
    output word_t     operand2
);

    word_t data_ext;
    word_t imm_ext;
    word_t ir_byte_ext;
    word_t quick_count;

    always_comb begin
        if (size[0])
            data_ext = {{24{data_read[7]}}, data_read[7:0]};
        else if (size[1])
            data_ext = {{16{data_read[15]}}, data_read[15:0]};
        else
            data_ext = data_read;
    end

    // Byte immediate sits in the low half of the extension word
    always_comb begin
        if (size[0])
            imm_ext = {{24{prefetch_ir[71]}}, prefetch_ir[71:64]};
        else if (size[1])
            imm_ext = {{16{prefetch_ir[79]}}, prefetch_ir[79:64]};
        else
            imm_ext = prefetch_ir[79:48];
    end

    assign ir_byte_ext = {{24{ir[7]}}, ir[7:0]};
    // Quick count of zero encodes 8
    assign quick_count = (ir[11:9] == 3'b000) ? 32'd8 : {29'd0, ir[11:9]};

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            operand1 <= OPERAND_RESET_VALUE;
        end else begin
            case (op1_ctl)
                OP1_FROM_OP2:       operand1 <= operand2;
                OP1_FROM_DATA:      operand1 <= data_ext;
                OP1_FROM_IMMEDIATE: operand1 <= imm_ext;
                OP1_FROM_RESULT:    operand1 <= result;
                OP1_MOVEQ:          operand1 <= ir_byte_ext;
                OP1_FROM_PC:        operand1 <= pc_valid;
                OP1_LOAD_ZEROS:     operand1 <= '0;
                OP1_LOAD_ONES:      operand1 <= '1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            operand2 <= OPERAND_RESET_VALUE;
        end else begin
            case (op2_ctl)
                OP2_FROM_OP1:    operand2 <= operand1;
                OP2_LOAD_1:      operand2 <= 32'd1;
                OP2_ADDQ_SUBQ:   operand2 <= quick_count;
                OP2_MOVE_OFFSET: begin
                    if (ir[7:0] != 8'd0)
                        operand2 <= ir_byte_ext;
                end
                OP2_DECR_BY_1:   operand2 <= operand2 - 32'd1;
                default: ;
            endcase
        end
    end

endmodule

/* rtl/pc_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program counter with its last-even copy.
// pc_change tells the prefetch unit how far pc moved.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module pc_unit import ao_regs_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  pc_ctl_e     pc_ctl,
    input  logic        main_loop_advance,
    input  size_t       size,
    input  word_t       result,
    input  prefetch_t   prefetch_ir,
    output word_t       pc,
    output word_t       pc_valid,
    output logic [1:0]  pc_change
);

    word_t pc_next;

    // 3 jump, 2 four bytes, 1 two bytes
    always_comb begin
        pc_next   = pc;
        pc_change = 2'd0;
        case (pc_ctl)
            PC_FROM_RESULT, PC_FROM_PREFETCH_IR: begin
                pc_next   = (pc_ctl == PC_FROM_RESULT) ? result : prefetch_ir[79:48];
                pc_change = 2'd3;
            end
            PC_INCR_BY_4: begin
                pc_next   = pc + 32'd4;
                pc_change = 2'd2;
            end
            PC_INCR_BY_2: begin
                pc_next   = pc + 32'd2;
                pc_change = 2'd1;
            end
            PC_INCR_BY_SIZE: begin
                pc_next   = size[2] ? pc + 32'd4 : pc + 32'd2;
                pc_change = size[2] ? 2'd2 : 2'd1;
            end
            PC_INCR_BY_2_IN_MAIN_LOOP: begin
                if (main_loop_advance) begin
                    pc_next   = pc + 32'd2;
                    pc_change = 2'd1;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pc       <= '0;
            pc_valid <= '0;
        end else begin
            pc <= pc_next;
            if (!pc_next[0])
                pc_valid <= pc_next;
        end
    end

    // Sequencer drives only defined PC controls
    pc_ctl_known: assert property (@(posedge clock) disable iff (!reset_n)
        !$isunknown(pc_ctl) && (pc_ctl <= PC_INCR_BY_2_IN_MAIN_LOOP));

endmodule

/* rtl/size_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One-hot operand size register.
// Set directly or decoded from the size field of ir.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module size_decoder import ao_regs_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    input  size_ctl_e size_ctl,
    input  half_t     ir,
    output size_t     size
);

    size_t size_next;

    always_comb begin
        size_next = size;
        case (size_ctl)
            SIZE_BYTE:   size_next = SZ_BYTE;
            SIZE_WORD:   size_next = SZ_WORD;
            SIZE_LONG:   size_next = SZ_LONG;
            SIZE_1:      size_next = (ir[7:6] == 2'b00) ? SZ_WORD : SZ_LONG;
            SIZE_1_PLUS: size_next = (ir[7:6] == 2'b10) ? SZ_WORD : SZ_LONG;
            SIZE_2:      size_next = ir[6] ? SZ_LONG : SZ_WORD;
            SIZE_3: begin
                if (ir[7])
                    size_next = SZ_LONG;
                else
                    size_next = ir[6] ? SZ_WORD : SZ_BYTE;
            end
            // MOVE size field
            SIZE_4: begin
                if (ir[13:12] == 2'b01)
                    size_next = SZ_BYTE;
                else if (ir[13:12] == 2'b11)
                    size_next = SZ_WORD;
                else
                    size_next = SZ_LONG;
            end
            SIZE_5:      size_next = ir[8] ? SZ_LONG : SZ_WORD;
            SIZE_6:      size_next = (ir[5:3] == 3'b000) ? SZ_LONG : SZ_BYTE;
            default: ;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n)
            size <= SZ_NONE;
        else
            size <= size_next;
    end

    // Codes above SIZE_6 are unused
    size_ctl_known: assert property (@(posedge clock) disable iff (!reset_n)
        !$isunknown(size_ctl) && (size_ctl <= SIZE_6));

endmodule

/* tests/microcode_regs_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the microcode register file.
// One control cycle per step, checked against a reference model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module microcode_regs_tb import ao_regs_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int SEED       = 74775;
    // Tests take about 200 cycles
    localparam int CYCLE_LIMIT = 2000;

    localparam logic [7:0] VEC_ILLEGAL   = 8'd4;
    localparam logic [7:0] VEC_DIV_ZERO  = 8'd5;
    localparam logic [7:0] VEC_CHK       = 8'd6;
    localparam logic [7:0] VEC_TRAPV     = 8'd7;
    localparam logic [7:0] VEC_PRIVILEGE = 8'd8;
    localparam logic [7:0] VEC_TRACE     = 8'd9;
    localparam logic [7:0] VEC_TRAP_BASE = 8'd32;

    typedef struct packed {
        logic [15:0] ir;
        logic        stop;
        logic [31:0] pc;
        logic [31:0] pc_valid;
        logic [2:0]  size;
        logic [31:0] op1;
        logic [31:0] op2;
        logic [31:0] addr;
        logic        addr_type;
        logic [7:0]  trap;
        logic [1:0]  change;
    } state_t;

    logic       clock = 1'b0;
    logic       reset_n;
    ir_ctl_e    ir_ctl;
    stop_ctl_e  stop_ctl;
    pc_ctl_e    pc_ctl;
    size_ctl_e  size_ctl;
    op1_ctl_e   op1_ctl;
    op2_ctl_e   op2_ctl;
    addr_ctl_e  addr_ctl;
    trap_ctl_e  trap_ctl;
    prefetch_t  prefetch_ir;
    logic       prefetch_ir_valid;
    word_t      data_read;
    word_t      result;
    trap_t      decoder_trap;
    half_t      ir;
    logic       stop_flag;
    word_t      pc;
    logic [1:0] pc_change;
    size_t      size;
    word_t      operand1;
    word_t      operand2;
    word_t      address;
    logic       address_type;
    trap_t      trap;

    state_t model;
    state_t expected;
    logic   pending = 1'b0;
    int     errors = 0;
    int     test_errors;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     cycles = 0;

    microcode_regs DUT (.clock, .reset_n, .ir_ctl, .stop_ctl, .pc_ctl, .size_ctl, .op1_ctl,
        .op2_ctl, .addr_ctl, .trap_ctl, .prefetch_ir, .prefetch_ir_valid, .data_read, .result,
        .decoder_trap, .ir, .stop_flag, .pc, .pc_change, .size, .operand1, .operand2,
        .address, .address_type, .trap);

    always #(CLK_PERIOD / 2) clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // Next register values from the current ones and the driven control fields
    function automatic state_t ref_next(input state_t s);
        state_t      n;
        logic        advance;
        logic [31:0] bytes;
        n = s;
        n.change = 2'd0;
        advance = prefetch_ir_valid && (decoder_trap == 8'd0) && !s.stop;
        if (ir_ctl == IR_LOAD_WHEN_PREFETCH_VALID && prefetch_ir_valid && !s.stop)
            n.ir = prefetch_ir[79:64];
        if (stop_ctl == STOP_SET)
            n.stop = 1'b1;
        else if (stop_ctl == STOP_CLEAR)
            n.stop = 1'b0;
        case (pc_ctl)
            PC_FROM_RESULT:      n.pc = result;
            PC_FROM_PREFETCH_IR: n.pc = prefetch_ir[79:48];
            PC_INCR_BY_2:        n.pc = s.pc + 32'd2;
            PC_INCR_BY_4:        n.pc = s.pc + 32'd4;
            PC_INCR_BY_SIZE:     n.pc = s.pc + ((s.size == 3'd4) ? 32'd4 : 32'd2);
            PC_INCR_BY_2_IN_MAIN_LOOP: begin
                if (advance)
                    n.pc = s.pc + 32'd2;
            end
            default: ;
        endcase
        // Step report follows from how far pc moved
        if (pc_ctl == PC_FROM_RESULT || pc_ctl == PC_FROM_PREFETCH_IR)
            n.change = 2'd3;
        else if (n.pc == s.pc + 32'd4)
            n.change = 2'd2;
        else if (n.pc == s.pc + 32'd2)
            n.change = 2'd1;
        if (!n.pc[0])
            n.pc_valid = n.pc;
        case (size_ctl)
            SIZE_BYTE:   n.size = 3'd1;
            SIZE_WORD:   n.size = 3'd2;
            SIZE_LONG:   n.size = 3'd4;
            SIZE_1:      n.size = (s.ir[7:6] == 2'd0) ? 3'd2 : 3'd4;
            SIZE_1_PLUS: n.size = (s.ir[7:6] == 2'd2) ? 3'd2 : 3'd4;
            SIZE_2:      n.size = s.ir[6] ? 3'd4 : 3'd2;
            SIZE_3:      n.size = s.ir[7] ? 3'd4 : (s.ir[6] ? 3'd2 : 3'd1);
            SIZE_4:      n.size = (s.ir[13:12] == 2'd1) ? 3'd1 :
                                  ((s.ir[13:12] == 2'd3) ? 3'd2 : 3'd4);
            SIZE_5:      n.size = s.ir[8] ? 3'd4 : 3'd2;
            SIZE_6:      n.size = (s.ir[5:3] == 3'd0) ? 3'd4 : 3'd1;
            default: ;
        endcase
        case (op1_ctl)
            OP1_FROM_OP2:    n.op1 = s.op2;
            OP1_FROM_DATA: begin
                case (s.size)
                    3'd1:    n.op1 = $signed(data_read[7:0]);
                    3'd2:    n.op1 = $signed(data_read[15:0]);
                    default: n.op1 = data_read;
                endcase
            end
            OP1_FROM_IMMEDIATE: begin
                case (s.size)
                    3'd1:    n.op1 = $signed(prefetch_ir[71:64]);
                    3'd2:    n.op1 = $signed(prefetch_ir[79:64]);
                    default: n.op1 = prefetch_ir[79:48];
                endcase
            end
            OP1_FROM_RESULT: n.op1 = result;
            OP1_MOVEQ:       n.op1 = $signed(s.ir[7:0]);
            OP1_FROM_PC:     n.op1 = s.pc_valid;
            OP1_LOAD_ZEROS:  n.op1 = 32'h0000_0000;
            OP1_LOAD_ONES:   n.op1 = 32'hFFFF_FFFF;
            default: ;
        endcase
        case (op2_ctl)
            OP2_FROM_OP1:  n.op2 = s.op1;
            OP2_LOAD_1:    n.op2 = 32'd1;
            OP2_ADDQ_SUBQ: n.op2 = (s.ir[11:9] == 3'd0) ? 32'd8 : {29'd0, s.ir[11:9]};
            OP2_MOVE_OFFSET: begin
                if (s.ir[7:0] != 8'd0)
                    n.op2 = $signed(s.ir[7:0]);
            end
            OP2_DECR_BY_1: n.op2 = s.op2 - 32'd1;
            default: ;
        endcase
        case (s.size)
            3'd1:    bytes = (s.ir[2:0] == 3'd7) ? 32'd2 : 32'd1;
            3'd2:    bytes = 32'd2;
            3'd4:    bytes = 32'd4;
            default: bytes = 32'd0;
        endcase
        case (addr_ctl)
            ADDR_INCR_BY_SIZE: n.addr = s.addr + bytes;
            ADDR_DECR_BY_SIZE: n.addr = s.addr - bytes;
            ADDR_INCR_BY_2:    n.addr = s.addr + 32'd2;
            ADDR_FROM_IMM_16:  n.addr = $signed(prefetch_ir[79:64]);
            ADDR_FROM_IMM_32:  n.addr = prefetch_ir[79:48];
            ADDR_FROM_TRAP:    n.addr = s.trap * 4;
            default: ;
        endcase
        if (addr_ctl != ADDR_IDLE)
            n.addr_type = 1'b0;
        case (trap_ctl)
            TRAP_ILLEGAL_INSTR: n.trap = VEC_ILLEGAL;
            TRAP_DIV_BY_ZERO:   n.trap = VEC_DIV_ZERO;
            TRAP_CHK:           n.trap = VEC_CHK;
            TRAP_TRAPV:         n.trap = VEC_TRAPV;
            TRAP_PRIVIL_VIOLAT: n.trap = VEC_PRIVILEGE;
            TRAP_TRACE:         n.trap = VEC_TRACE;
            TRAP_TRAP:          n.trap = VEC_TRAP_BASE + s.ir[3:0];
            TRAP_FROM_DECODER:  n.trap = decoder_trap;
            default: ;
        endcase
        return n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    // pc_change mid low phase, registers a quarter period after the edge
    always begin
        @(negedge clock);
        #(CLK_PERIOD / 4);
        if (pending) begin
            check_value("pc_change", pc_change, expected.change);
            @(posedge clock);
            #(CLK_PERIOD / 4);
            check_value("ir", ir, expected.ir);
            check_value("stop_flag", stop_flag, expected.stop);
            check_value("pc", pc, expected.pc);
            check_value("size", size, expected.size);
            check_value("operand1", operand1, expected.op1);
            check_value("operand2", operand2, expected.op2);
            check_value("address", address, expected.addr);
            check_value("address_type", address_type, expected.addr_type);
            check_value("trap", trap, expected.trap);
            pending = 1'b0;
        end
    end

    task automatic begin_cycle;
        logic [15:0] upper;
        @(negedge clock);
        upper = $urandom;
        ir_ctl = IR_IDLE;
        stop_ctl = STOP_IDLE;
        pc_ctl = PC_IDLE;
        size_ctl = SIZE_IDLE;
        op1_ctl = OP1_IDLE;
        op2_ctl = OP2_IDLE;
        addr_ctl = ADDR_IDLE;
        trap_ctl = TRAP_IDLE;
        prefetch_ir = {upper, $urandom, $urandom};
        prefetch_ir_valid = 1'b0;
        data_read = $urandom;
        result = $urandom;
        decoder_trap = 8'd0;
    endtask

    task automatic end_cycle;
        expected = ref_next(model);
        model = expected;
        pending = 1'b1;
        wait (!pending);
    endtask

    task automatic load_ir(input logic [15:0] value);
        begin_cycle();
        ir_ctl = IR_LOAD_WHEN_PREFETCH_VALID;
        prefetch_ir_valid = 1'b1;
        prefetch_ir[79:64] = value;
        end_cycle();
    endtask

    task automatic start_test;
        test_errors = errors;
        tests_run++;
    endtask

    task automatic finish_test(input string name);
        if (errors == test_errors) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, errors - test_errors);
            tests_failed++;
        end
    endtask

    initial begin
        int          k;
        int          r;
        logic [15:0] v;
        size_ctl_e   sel;
        void'($urandom(SEED));
        reset_n = 1'b0;
        ir_ctl = IR_IDLE;
        stop_ctl = STOP_IDLE;
        pc_ctl = PC_IDLE;
        size_ctl = SIZE_IDLE;
        op1_ctl = OP1_IDLE;
        op2_ctl = OP2_IDLE;
        addr_ctl = ADDR_IDLE;
        trap_ctl = TRAP_IDLE;
        prefetch_ir = '0;
        prefetch_ir_valid = 1'b0;
        data_read = '0;
        result = '0;
        decoder_trap = '0;
        model = '0;
        model.op1 = 32'hFFFF_FFFF;
        model.op2 = 32'hFFFF_FFFF;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        start_test();
        check_value("pc", pc, 32'd0);
        check_value("operand1", operand1, 32'hFFFF_FFFF);
        check_value("operand2", operand2, 32'hFFFF_FFFF);
        check_value("size", size, 32'd0);
        check_value("stop_flag", stop_flag, 32'd0);
        check_value("ir", ir, 32'd0);
        finish_test("reset values");

        start_test();
        load_ir($urandom);
        begin_cycle();
        pc_ctl = PC_INCR_BY_2_IN_MAIN_LOOP;
        prefetch_ir_valid = 1'b1;
        end_cycle();
        begin_cycle();
        stop_ctl = STOP_SET;
        end_cycle();
        // Stopped core ignores both loads
        begin_cycle();
        ir_ctl = IR_LOAD_WHEN_PREFETCH_VALID;
        pc_ctl = PC_INCR_BY_2_IN_MAIN_LOOP;
        prefetch_ir_valid = 1'b1;
        end_cycle();
        begin_cycle();
        stop_ctl = STOP_CLEAR;
        end_cycle();
        begin_cycle();
        pc_ctl = PC_INCR_BY_2_IN_MAIN_LOOP;
        prefetch_ir_valid = 1'b1;
        decoder_trap = ($urandom % 255) + 1;
        end_cycle();
        begin_cycle();
        pc_ctl = PC_INCR_BY_2_IN_MAIN_LOOP;
        prefetch_ir_valid = 1'b1;
        end_cycle();
        finish_test("ir load and main loop");

        start_test();
        for (k = 1; k <= 10; k++) begin
            for (r = 0; r < 4; r++) begin
                load_ir($urandom);
                begin_cycle();
                size_ctl = size_ctl_e'(k);
                end_cycle();
                begin_cycle();
                pc_ctl = PC_INCR_BY_SIZE;
                end_cycle();
            end
        end
        finish_test("size decode and pc step");

        start_test();
        for (k = 0; k < 3; k++) begin
            begin_cycle();
            size_ctl = size_ctl_e'(SIZE_BYTE + k);
            end_cycle();
            for (r = 0; r < 3; r++) begin
                begin_cycle();
                op1_ctl = OP1_FROM_DATA;
                end_cycle();
            end
        end
        load_ir($urandom);
        begin_cycle();
        op1_ctl = OP1_MOVEQ;
        op2_ctl = OP2_MOVE_OFFSET;
        end_cycle();
        load_ir($urandom & 16'hF100);
        begin_cycle();
        op2_ctl = OP2_ADDQ_SUBQ;
        op1_ctl = OP1_FROM_PC;
        end_cycle();
        for (r = 0; r < 3; r++) begin
            begin_cycle();
            op2_ctl = OP2_DECR_BY_1;
            end_cycle();
        end
        begin_cycle();
        op2_ctl = OP2_MOVE_OFFSET;
        end_cycle();
        load_ir($urandom | 16'h0200);
        begin_cycle();
        op2_ctl = OP2_ADDQ_SUBQ;
        end_cycle();
        finish_test("operand loads");

        start_test();
        begin_cycle();
        addr_ctl = ADDR_FROM_IMM_32;
        end_cycle();
        for (k = 0; k < 4; k++) begin
            v = $urandom & 16'hFFF8;
            sel = (k == 2) ? SIZE_WORD : ((k == 3) ? SIZE_LONG : SIZE_BYTE);
            if (k == 0)
                v = v | 16'd7;
            else
                v = v | ($urandom % 7);
            load_ir(v);
            begin_cycle();
            size_ctl = sel;
            end_cycle();
            for (r = 0; r < 3; r++) begin
                begin_cycle();
                addr_ctl = (r == 2) ? ADDR_DECR_BY_SIZE : ADDR_INCR_BY_SIZE;
                end_cycle();
            end
        end
        for (r = 0; r < 2; r++) begin
            begin_cycle();
            addr_ctl = ADDR_FROM_IMM_16;
            prefetch_ir[79] = (r == 0);
            end_cycle();
        end
        begin_cycle();
        addr_ctl = ADDR_INCR_BY_2;
        end_cycle();
        finish_test("address steps");

        start_test();
        for (k = 1; k <= 8; k++) begin
            if (trap_ctl_e'(k) == TRAP_TRAP)
                load_ir($urandom);
            begin_cycle();
            trap_ctl = trap_ctl_e'(k);
            decoder_trap = ($urandom % 255) + 1;
            end_cycle();
            begin_cycle();
            addr_ctl = ADDR_FROM_TRAP;
            end_cycle();
        end
        finish_test("trap vectors");

        $display("%0d tests run, %0d with mismatches, %0d mismatches in total",
            tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule
